//--- hw/fifo_pkg.sv
`default_nettype none

package fifo_pkg;

	//////////////////////////////////////////////////
	// Sizes

	// Word width on the bus and in storage
	localparam int data_w      = 32;
	localparam int strb_w      = data_w / 8;
	localparam int axil_addr_w = 4;

	// FIFO geometry, level counts 0 through fifo_depth
	localparam int fifo_depth  = 16;
	localparam int ptr_w       = 4;
	localparam int level_w     = 5;

	//////////////////////////////////////////////////
	// Register map and response codes

	localparam logic [axil_addr_w-1:0] reg_data  = 'h0;
	localparam logic [axil_addr_w-1:0] reg_level = 'h4;

	localparam logic [1:0] resp_okay   = 2'b00;
	localparam logic [1:0] resp_slverr = 2'b10;

	//////////////////////////////////////////////////
	// Types

	typedef logic [data_w-1:0] word_t;

	// Push request from the write port into the FIFO
	typedef struct packed {
		logic  valid;
		word_t data;
	} fifo_push_t;

	// FIFO state seen by both bus ports
	typedef struct packed {
		logic [level_w-1:0] level;
		logic               empty;
		logic               full;
	} fifo_status_t;

	// AW and W payloads together
	typedef struct packed {
		logic [axil_addr_w-1:0] awaddr;
		word_t                  wdata;
		logic [strb_w-1:0]      wstrb;
	} axil_wr_t;

	// R payload
	typedef struct packed {
		word_t      rdata;
		logic [1:0] rresp;
	} axil_rd_t;

endpackage

`default_nettype wire

//--- hw/memory_macro.sv
`default_nettype none

module memory_macro #(
	parameter int WIDTH = 32,
	parameter int DEPTH = 16,
	// Address bits follow from the depth
	localparam int addr_w = $clog2(DEPTH)
) (
	input  wire logic              porta_clk,

	// Port A writes only
	input  wire logic              porta_en,
	input  wire logic              porta_we,
	input  wire logic [addr_w-1:0] porta_addr,
	input  wire logic [WIDTH-1:0]  porta_din,

	// Port B reads only, one output register stage
	input  wire logic              portb_en,
	input  wire logic [addr_w-1:0] portb_addr,
	output logic      [WIDTH-1:0]  portb_dout
);

	//////////////////////////////////////////////////
	// Storage array

	logic [WIDTH-1:0] storage [DEPTH];

	// Start from an all-zero array
	initial begin
		for (int i = 0; i < DEPTH; i++) begin
			storage[i] = '0;
		end
	end

	//////////////////////////////////////////////////
	// Port A

	// Write needs both enable and write enable
	always_ff @(posedge porta_clk) begin
		if (porta_en && porta_we) begin
			storage[porta_addr] <= porta_din;
		end
	end

	//////////////////////////////////////////////////
	// Port B

	// Output register also starts at zero
	logic [WIDTH-1:0] portb_q = '0;

	// Registered read
	// Holds the last word while portb_en is low
	always_ff @(posedge porta_clk) begin
		if (portb_en) begin
			portb_q <= storage[portb_addr];
		end
	end

	// The caller never reads the slot being written in the same cycle
	assign portb_dout = portb_q;

endmodule

`default_nettype wire

//--- hw/axil_push_port.sv
`default_nettype none

module axil_push_port
	import fifo_pkg::*;
(
	input  wire logic         porta_clk,
	input  wire logic         reset,

	// AW and W channels, payloads bundled
	input  wire logic         awvalid,
	output logic              awready,
	input  wire logic         wvalid,
	output logic              wready,
	input  wire axil_wr_t     wr,

	// B channel
	output logic              bvalid,
	input  wire logic         bready,
	output logic [1:0]        bresp,

	// FIFO side
	input  wire fifo_status_t status,
	output fifo_push_t        push
);

	logic out_of_reset;
	logic wr_fire;
	logic is_data;
	logic accept;

	//////////////////////////////////////////////////
	// Request acceptance

	// Ready stays low through reset and for its last edge
	always_ff @(posedge porta_clk) begin
		if (reset) begin
			out_of_reset <= 1'b0;
		end else begin
			out_of_reset <= 1'b1;
		end
	end

	// Address and data beats only taken as a pair
	// Blocked while a B response waits
	assign wr_fire = out_of_reset & awvalid & wvalid & ~bvalid;
	assign awready = wr_fire;
	assign wready  = wr_fire;

	// Offset decode
	// wstrb not looked at since every write is a full word
	assign is_data = (wr.awaddr == reg_data);

	// Full check lives here only
	assign accept = wr_fire & is_data & ~status.full;

	always_comb begin
		push.valid = accept;
		push.data  = wr.wdata;
	end

	//////////////////////////////////////////////////
	// Write response

	// bvalid one cycle after the handshake, held until bready
	always_ff @(posedge porta_clk) begin
		if (reset) begin
			bvalid <= 1'b0;
		end else if (wr_fire) begin
			bvalid <= 1'b1;
		end else if (bready) begin
			bvalid <= 1'b0;
		end
	end

	// Dropped pushes and bad offsets both report SLVERR
	always_ff @(posedge porta_clk) begin
		if (wr_fire) begin
			bresp <= accept ? resp_okay : resp_slverr;
		end
	end

endmodule

`default_nettype wire

//--- hw/ring_fifo.sv
`default_nettype none

module ring_fifo
	import fifo_pkg::*;
(
	input  wire logic       porta_clk,
	input  wire logic       reset,

	// Push from the write port, never issued while full
	input  wire fifo_push_t push,

	// Pop from the read port, never issued while empty
	input  wire logic       pop,
	output word_t           pop_data,

	output fifo_status_t    status
);

	logic [ptr_w-1:0]   wr_ptr;
	logic [ptr_w-1:0]   rd_ptr;
	logic [level_w-1:0] level;

	//////////////////////////////////////////////////
	// Pointers

	// Both pointers wrap after the last slot
	always_ff @(posedge porta_clk) begin
		if (reset) begin
			wr_ptr <= '0;
		end else if (push.valid) begin
			if (wr_ptr == ptr_w'(fifo_depth - 1)) begin
				wr_ptr <= '0;
			end else begin
				wr_ptr <= wr_ptr + 1'b1;
			end
		end
	end

	always_ff @(posedge porta_clk) begin
		if (reset) begin
			rd_ptr <= '0;
		end else if (pop) begin
			if (rd_ptr == ptr_w'(fifo_depth - 1)) begin
				rd_ptr <= '0;
			end else begin
				rd_ptr <= rd_ptr + 1'b1;
			end
		end
	end

	//////////////////////////////////////////////////
	// Fill level

	// Push and pop together leave the level as it is
	always_ff @(posedge porta_clk) begin
		if (reset) begin
			level <= '0;
		end else begin
			case ({push.valid, pop})
				2'b10:   level <= level + 1'b1;
				2'b01:   level <= level - 1'b1;
				default: level <= level;
			endcase
		end
	end

	// Flags decoded from the level register
	always_comb begin
		status.level = level;
		status.empty = (level == '0);
		status.full  = (level == level_w'(fifo_depth));
	end

	//////////////////////////////////////////////////
	// Storage

	// Write pointer on port A and read pointer on port B
	// Popped word appears one cycle after pop and then holds
	memory_macro #(
		.WIDTH(data_w),
		.DEPTH(fifo_depth)
	) u_mem (
		.porta_clk  (porta_clk),
		.porta_en   (1'b1),
		.porta_we   (push.valid),
		.porta_addr (wr_ptr),
		.porta_din  (push.data),
		.portb_en   (pop),
		.portb_addr (rd_ptr),
		.portb_dout (pop_data)
	);

endmodule

`default_nettype wire

//--- hw/axil_pop_port.sv
`default_nettype none

module axil_pop_port
	import fifo_pkg::*;
(
	input  wire logic                   porta_clk,
	input  wire logic                   reset,

	// AR channel
	input  wire logic                   arvalid,
	output logic                        arready,
	input  wire logic [axil_addr_w-1:0] araddr,

	// R channel, payload bundled
	output logic                        rvalid,
	input  wire logic                   rready,
	output axil_rd_t                    rd,

	// FIFO side
	input  wire fifo_status_t           status,
	output logic                        pop,
	input  wire word_t                  pop_data
);

	// Kind of read response waiting on the R channel
	typedef enum logic [1:0] {
		rsp_pop,
		rsp_level,
		rsp_err
	} rsp_kind_t;

	logic               out_of_reset;
	logic               ar_fire;
	logic               is_data;
	logic               is_level;
	rsp_kind_t          kind_q;
	logic [level_w-1:0] level_q;

	//////////////////////////////////////////////////
	// Address acceptance

	always_ff @(posedge porta_clk) begin
		if (reset) begin
			out_of_reset <= 1'b0;
		end else begin
			out_of_reset <= 1'b1;
		end
	end

	// One read in flight at a time
	assign arready = out_of_reset & ~rvalid;
	assign ar_fire = arvalid & arready;

	// Offset decode
	assign is_data  = (araddr == reg_data);
	assign is_level = (araddr == reg_level);

	// Empty check lives here only
	assign pop = ar_fire & is_data & ~status.empty;

	//////////////////////////////////////////////////
	// Pending response

	// rvalid one cycle after the AR handshake, held until rready
	always_ff @(posedge porta_clk) begin
		if (reset) begin
			rvalid <= 1'b0;
		end else if (ar_fire) begin
			rvalid <= 1'b1;
		end else if (rready) begin
			rvalid <= 1'b0;
		end
	end

	// Response kind and level as seen in the handshake cycle
	always_ff @(posedge porta_clk) begin
		if (ar_fire) begin
			level_q <= status.level;
			if (pop) begin
				kind_q <= rsp_pop;
			end else if (is_level) begin
				kind_q <= rsp_level;
			end else begin
				kind_q <= rsp_err;
			end
		end
	end

	//////////////////////////////////////////////////
	// Read data

	// pop_data stays put in the macro register while R stalls
	always_comb begin
		rd.rdata = '0;
		rd.rresp = resp_okay;
		case (kind_q)
			rsp_pop:   rd.rdata = pop_data;
			rsp_level: rd.rdata = word_t'(level_q);
			default:   rd.rresp = resp_slverr;
		endcase
	end

endmodule

`default_nettype wire

//--- hw/axil_fifo_top.sv
`default_nettype none

module axil_fifo_top
	import fifo_pkg::*;
(
	input  wire logic                   porta_clk,
	input  wire logic                   reset,

	// Write address and data
	input  wire logic                   awvalid,
	output logic                        awready,
	input  wire logic                   wvalid,
	output logic                        wready,
	input  wire axil_wr_t               wr,

	// Write response
	output logic                        bvalid,
	input  wire logic                   bready,
	output logic [1:0]                  bresp,

	// Read address
	input  wire logic                   arvalid,
	output logic                        arready,
	input  wire logic [axil_addr_w-1:0] araddr,

	// Read data
	output logic                        rvalid,
	input  wire logic                   rready,
	output axil_rd_t                    rd
);

	fifo_push_t   push;
	fifo_status_t status;
	logic         pop;
	word_t        pop_data;

	//////////////////////////////////////////////////
	// Producer side

	axil_push_port u_push (
		.porta_clk (porta_clk),
		.reset     (reset),
		.awvalid   (awvalid),
		.awready   (awready),
		.wvalid    (wvalid),
		.wready    (wready),
		.wr        (wr),
		.bvalid    (bvalid),
		.bready    (bready),
		.bresp     (bresp),
		.status    (status),
		.push      (push)
	);

	//////////////////////////////////////////////////
	// Buffer

	ring_fifo u_fifo (
		.porta_clk (porta_clk),
		.reset     (reset),
		.push      (push),
		.pop       (pop),
		.pop_data  (pop_data),
		.status    (status)
	);

	//////////////////////////////////////////////////
	// Consumer side

	axil_pop_port u_pop (
		.porta_clk (porta_clk),
		.reset     (reset),
		.arvalid   (arvalid),
		.arready   (arready),
		.araddr    (araddr),
		.rvalid    (rvalid),
		.rready    (rready),
		.rd        (rd),
		.status    (status),
		.pop       (pop),
		.pop_data  (pop_data)
	);

endmodule

`default_nettype wire

//--- tb/tb_axil_fifo_assert.sv
`default_nettype none

module tb_axil_fifo_assert
	import fifo_pkg::*;
(
	input wire logic         porta_clk,
	input wire logic         reset,
	input wire logic         bvalid,
	input wire logic         bready,
	input wire logic [1:0]   bresp,
	input wire logic         rvalid,
	input wire logic         rready,
	input wire axil_rd_t     rd,
	input wire fifo_push_t   push,
	input wire logic         pop,
	input wire fifo_status_t status
);

	timeunit 1ns;
	timeprecision 1ps;

	//////////////////////////////////////////////////
	// Response channels

	// B response frozen while the master stalls
	b_hold: assert property (@(posedge porta_clk) disable iff (reset)
		bvalid && !bready |=> bvalid && $stable(bresp))
		else $error("bvalid or bresp changed before bready");

	// R response frozen while the master stalls
	r_hold: assert property (@(posedge porta_clk) disable iff (reset)
		rvalid && !rready |=> rvalid && $stable(rd))
		else $error("rvalid or read payload changed before rready");

	//////////////////////////////////////////////////
	// FIFO side

	// Push port must have filtered the full case
	no_push_full: assert property (@(posedge porta_clk) disable iff (reset)
		push.valid |-> !status.full)
		else $error("push issued while FIFO full");

	// Pop port must have filtered the empty case
	no_pop_empty: assert property (@(posedge porta_clk) disable iff (reset)
		pop |-> !status.empty)
		else $error("pop issued while FIFO empty");

endmodule

`default_nettype wire

//--- tb/tb_axil_fifo.sv
`default_nettype none

module tb_axil_fifo
	import fifo_pkg::*;
();

	timeunit 1ns;
	timeprecision 1ps;

	localparam int clk_half     = 50;
	localparam int reset_cycles = 10;
	localparam int wait_limit   = 200;
	localparam int mixed_ops    = 80;

	// One finished bus operation as seen on the bus
	typedef struct packed {
		logic                   is_write;
		logic [axil_addr_w-1:0] addr;
		word_t                  wdata;
		logic [1:0]             resp;
		word_t                  data;
	} bus_op_t;

	// Expected response
	typedef struct packed {
		logic [1:0] resp;
		word_t      data;
	} bus_rsp_t;

	logic       porta_clk;
	logic       reset;
	logic       awvalid;
	logic       awready;
	logic       wvalid;
	logic       wready;
	axil_wr_t   wr;
	logic       bvalid;
	logic       bready;
	logic [1:0] bresp;
	logic       arvalid;
	logic       arready;
	logic [axil_addr_w-1:0] araddr;
	logic       rvalid;
	logic       rready;
	axil_rd_t   rd;

	logic [15:0] lfsr = 16'd59961;
	word_t       ref_q[$];
	bus_op_t     seen_q[$];
	string       seen_name[$];
	int          issued = 0;
	int          checked = 0;

	axil_fifo_top u_dut (
		.porta_clk (porta_clk),
		.reset     (reset),
		.awvalid   (awvalid),
		.awready   (awready),
		.wvalid    (wvalid),
		.wready    (wready),
		.wr        (wr),
		.bvalid    (bvalid),
		.bready    (bready),
		.bresp     (bresp),
		.arvalid   (arvalid),
		.arready   (arready),
		.araddr    (araddr),
		.rvalid    (rvalid),
		.rready    (rready),
		.rd        (rd)
	);

	// Protocol checks on the top level and its internal FIFO nets
	bind axil_fifo_top tb_axil_fifo_assert u_assert (
		.porta_clk (porta_clk),
		.reset     (reset),
		.bvalid    (bvalid),
		.bready    (bready),
		.bresp     (bresp),
		.rvalid    (rvalid),
		.rready    (rready),
		.rd        (rd),
		.push      (push),
		.pop       (pop),
		.status    (status)
	);

	initial begin : clock_gen
		porta_clk = 1'b0;
		forever begin
			#(clk_half) porta_clk = ~porta_clk;
		end
	end

	//////////////////////////////////////////////////
	// Random source

	// Galois step, taps x^16 + x^14 + x^13 + x^11 + 1
	function automatic logic [15:0] lfsr_next(input logic [15:0] s);
		logic [15:0] n;
		n = {1'b0, s[15:1]};
		if (s[0]) begin
			n = n ^ 16'hB400;
		end
		return n;
	endfunction

	// One step per bit taken
	task automatic take_bits(input int n, output logic [31:0] val);
		val = '0;
		for (int i = 0; i < n; i++) begin
			val  = {val[30:0], lfsr[0]};
			lfsr = lfsr_next(lfsr);
		end
	endtask

	//////////////////////////////////////////////////
	// Reference model

	// Register map and error rules over a 16 deep queue
	function automatic bus_rsp_t model_response(input bus_op_t op);
		bus_rsp_t r;
		r.resp = 2'b10;
		r.data = '0;
		if (op.is_write) begin
			// Only offset 0 takes data, and only with room left
			if (op.addr == 4'h0 && ref_q.size() < 16) begin
				ref_q.push_back(op.wdata);
				r.resp = 2'b00;
			end
		end else if (op.addr == 4'h0) begin
			if (ref_q.size() > 0) begin
				r.data = ref_q.pop_front();
				r.resp = 2'b00;
			end
		end else if (op.addr == 4'h4) begin
			r.data = word_t'(ref_q.size());
			r.resp = 2'b00;
		end
		return r;
	endfunction

	//////////////////////////////////////////////////
	// Checking

	task automatic check_value(input string name, input logic [63:0] exp_v,
			input logic [63:0] act_v);
		if (exp_v !== act_v) begin
			$display("error %s expected %0h actual %0h", name, exp_v, act_v);
			$display("Verification failed");
			$fatal(1, "value mismatch in %s", name);
		end
	endtask

	task automatic report_timeout(input string what);
		$display("%s within %0d clock cycles", what, wait_limit);
		$display("Verification failed");
		$fatal(1, "timeout");
	endtask

	// Each response replayed through the model in bus order
	initial begin : compare
		bus_op_t  op;
		bus_rsp_t exp_r;
		string    name;
		forever begin
			@(negedge porta_clk);
			while (seen_q.size() > 0) begin
				op    = seen_q.pop_front();
				name  = seen_name.pop_front();
				exp_r = model_response(op);
				check_value({name, " resp"}, 64'(exp_r.resp), 64'(op.resp));
				if (!op.is_write) begin
					check_value({name, " data"}, 64'(exp_r.data), 64'(op.data));
				end
				checked++;
			end
		end
	end

	//////////////////////////////////////////////////
	// Bus tasks

	// Entered and left on a falling edge
	task automatic axil_write(input string name, input logic [axil_addr_w-1:0] addr,
			input word_t data);
		bus_op_t     op;
		logic [31:0] stall;
		int          n;
		wr.awaddr = addr;
		wr.wdata  = data;
		wr.wstrb  = '1;
		awvalid   = 1'b1;
		wvalid    = 1'b1;
		n = 0;
		// Both beats are taken on the same rising edge
		do begin
			@(posedge porta_clk);
			n++;
		end while (!awready && !wready && n < wait_limit);
		if (!awready && !wready) begin
			report_timeout("AW and W channels never became ready");
		end
		check_value({name, " awready"}, 64'(1'b1), 64'(awready));
		check_value({name, " wready"}, 64'(1'b1), 64'(wready));
		@(negedge porta_clk);
		awvalid = 1'b0;
		wvalid  = 1'b0;
		// B response one cycle after the handshake
		check_value({name, " bvalid"}, 64'(1'b1), 64'(bvalid));
		// Random back-pressure on B
		take_bits(2, stall);
		repeat (stall) @(negedge porta_clk);
		op.is_write = 1'b1;
		op.addr     = addr;
		op.wdata    = data;
		op.resp     = bresp;
		op.data     = '0;
		bready = 1'b1;
		@(negedge porta_clk);
		bready = 1'b0;
		seen_q.push_back(op);
		seen_name.push_back(name);
		issued++;
	endtask

	task automatic axil_read(input string name, input logic [axil_addr_w-1:0] addr);
		bus_op_t     op;
		logic [31:0] stall;
		int          n;
		araddr  = addr;
		arvalid = 1'b1;
		n = 0;
		do begin
			@(posedge porta_clk);
			n++;
		end while (!arready && n < wait_limit);
		if (!arready) begin
			report_timeout("AR channel never became ready");
		end
		@(negedge porta_clk);
		arvalid = 1'b0;
		// R response one cycle after the handshake
		check_value({name, " rvalid"}, 64'(1'b1), 64'(rvalid));
		// Random back-pressure on R
		take_bits(2, stall);
		repeat (stall) @(negedge porta_clk);
		op.is_write = 1'b0;
		op.addr     = addr;
		op.wdata    = '0;
		op.resp     = rd.rresp;
		op.data     = rd.rdata;
		rready = 1'b1;
		@(negedge porta_clk);
		rready = 1'b0;
		seen_q.push_back(op);
		seen_name.push_back(name);
		issued++;
	endtask

	//////////////////////////////////////////////////
	// Stimulus

	initial begin : stimulus
		logic [31:0] pick;
		int          n;
		reset   = 1'b1;
		awvalid = 1'b0;
		wvalid  = 1'b0;
		wr      = '0;
		bready  = 1'b0;
		arvalid = 1'b0;
		araddr  = '0;
		rready  = 1'b0;
		repeat (reset_cycles) @(negedge porta_clk);
		reset = 1'b0;

		// Empty FIFO after reset
		axil_read("reset level", 4'h4);
		axil_read("empty pop", 4'h0);

		// Fill, level counts up
		for (int i = 0; i < 16; i++) begin
			take_bits(32, pick);
			axil_write("fill push", 4'h0, pick);
			axil_read("fill level", 4'h4);
		end
		// Seventeenth word is dropped
		take_bits(32, pick);
		axil_write("overflow push", 4'h0, pick);
		axil_read("full level", 4'h4);
		for (int i = 0; i < 16; i++) begin
			axil_read("drain pop", 4'h0);
		end
		axil_read("after drain pop", 4'h0);

		// Bad offsets and a level write leave the contents alone
		axil_write("seed push", 4'h0, 32'h1234_5678);
		axil_write("seed push", 4'h0, 32'h9abc_def0);
		axil_write("level write", 4'h4, 32'hffff_ffff);
		axil_write("offset 8 write", 4'h8, 32'h0bad_0008);
		axil_write("offset c write", 4'hc, 32'h0bad_000c);
		axil_read("offset 8 read", 4'h8);
		axil_read("offset 2 read", 4'h2);
		axil_read("bad offset level", 4'h4);
		axil_read("seed pop", 4'h0);
		axil_read("seed pop", 4'h0);

		// Mixed traffic with random stalls
		for (int i = 0; i < mixed_ops; i++) begin
			take_bits(3, pick);
			if (pick[2:0] < 3'd3) begin
				take_bits(32, pick);
				axil_write("mixed push", 4'h0, pick);
			end else if (pick[2:0] < 3'd6) begin
				axil_read("mixed pop", 4'h0);
			end else begin
				axil_read("mixed level", 4'h4);
			end
		end
		for (int i = 0; i < 17; i++) begin
			axil_read("final pop", 4'h0);
		end
		axil_read("final level", 4'h4);

		// Let the compare process catch up
		n = 0;
		while (checked < issued && n < wait_limit) begin
			@(negedge porta_clk);
			n++;
		end

		if (checked == issued) begin
			$display("Verification passed");
			$finish;
		end else begin
			report_timeout("compare process did not finish its checks");
		end
	end

endmodule

`default_nettype wire

//--- project.f
hw/fifo_pkg.sv
hw/memory_macro.sv
hw/axil_push_port.sv
hw/ring_fifo.sv
hw/axil_pop_port.sv
hw/axil_fifo_top.sv
tb/tb_axil_fifo_assert.sv
tb/tb_axil_fifo.sv

//--- run.sh
#!/bin/sh
# Build and run the AXI4-Lite FIFO testbench with Verilator
set -e

cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing --assert -j 0 \
	--top-module tb_axil_fifo \
	-f project.f \
	-o sim_tb

# The log decides the result, not the simulator exit code
./obj_dir/sim_tb > sim.log 2>&1 || true
cat sim.log

if grep -qx "Verification passed" sim.log; then
	exit 0
fi
exit 1
